// ==== piano_cfg_pkg.sv ====
/* Piano trainer configuration constants
   Note codes, key count, register map and the tone half-period table */
package piano_cfg_pkg;

    localparam int num_keys   = 13;
    localparam int note_w     = 4;
    localparam int max_octave = 3;
    localparam int oct_w      = $clog2(max_octave + 1);

    // Code 0 is rest, keys are 1 (C4) up to 13 (C5)
    localparam logic [note_w-1:0] note_rest = '0;

    // Wishbone word address and data widths
    localparam int adr_w  = 8;
    localparam int data_w = 32;

    // Song entries sit at words 0 .. song_depth-1, registers above them
    localparam logic [adr_w-1:0] reg_ctrl_adr   = 8'hf0;
    localparam logic [adr_w-1:0] reg_status_adr = 8'hf1;

    // Control register layout
    localparam int len_w          = 8;
    localparam int timeout_w      = 16;
    localparam int ctrl_len_lsb   = 0;
    localparam int ctrl_oct_lsb   = 8;
    localparam int ctrl_start_bit = 15;
    localparam int ctrl_tmo_lsb   = 16;

    // Counter width as seen in the status word
    localparam int stat_cnt_w = 10;
    localparam int half_w     = 12;

    // Half period in cycles of a 1 MHz clock, octave 0
    function automatic logic [half_w-1:0] note_half_period(input logic [note_w-1:0] note);
        case (note)
            4'd1:    return 12'd1911;
            4'd2:    return 12'd1804;
            4'd3:    return 12'd1703;
            4'd4:    return 12'd1607;
            4'd5:    return 12'd1517;
            4'd6:    return 12'd1432;
            4'd7:    return 12'd1351;
            4'd8:    return 12'd1276;
            4'd9:    return 12'd1204;
            4'd10:   return 12'd1136;
            4'd11:   return 12'd1073;
            4'd12:   return 12'd1012;
            4'd13:   return 12'd956;
            default: return 12'd0;
        endcase
    endfunction

endpackage

// ==== piano_types_pkg.sv ====
/* Piano trainer bus and data path types
   Wishbone request and response, song steps, key events and lesson state */
package piano_types_pkg;

    typedef struct packed {
        logic                               cyc;
        logic                               stb;
        logic                               we;
        logic [piano_cfg_pkg::adr_w-1:0]    adr;
        logic [piano_cfg_pkg::data_w-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic                               ack;
        logic [piano_cfg_pkg::data_w-1:0]   dat;
    } wb_rsp_t;

    // One step of the song
    typedef struct packed {
        logic [piano_cfg_pkg::note_w-1:0] note;
    } song_entry_t;

    // Held note and a one-cycle flag for a new press
    typedef struct packed {
        logic [piano_cfg_pkg::note_w-1:0] note;
        logic                             press;
    } key_event_t;

    typedef struct packed {
        logic [piano_cfg_pkg::len_w-1:0]     length;
        logic [piano_cfg_pkg::oct_w-1:0]     octave;
        logic [piano_cfg_pkg::timeout_w-1:0] timeout;
        logic                                start;
    } lesson_cfg_t;

    // Misses sit in the low bits of the status word
    typedef struct packed {
        logic                                 running;
        logic                                 done;
        logic [piano_cfg_pkg::len_w-1:0]      step;
        logic [piano_cfg_pkg::stat_cnt_w-1:0] hits;
        logic [piano_cfg_pkg::stat_cnt_w-1:0] misses;
    } lesson_status_t;

endpackage

// ==== key_scanner.sv ====
/* Key scanner
   Debounces the 13 keys, encodes the lowest one and flags each new press */
`timescale 1ns/1ps

module key_scanner #(
    parameter int debounce_cycles = 8
) (
    input  logic                                clock,
    input  logic                                rst,
    input  logic [piano_cfg_pkg::num_keys-1:0]  keys,
    output piano_types_pkg::key_event_t         key_event
);

    localparam int nk    = piano_cfg_pkg::num_keys;
    localparam int nw    = piano_cfg_pkg::note_w;
    localparam int cnt_w = $clog2(debounce_cycles + 1);

    logic [nk-1:0]    sample_q;
    logic [nk-1:0]    stable_q;
    logic [cnt_w-1:0] stable_cnt_q;
    logic [nw-1:0]    note_enc;
    logic [nw-1:0]    note_q;
    logic             press_q;

    // Raw keys must stay the same for debounce_cycles before they count
    always_ff @(posedge clock) begin
        if (rst) begin
            sample_q     <= '0;
            stable_q     <= '0;
            stable_cnt_q <= '0;
        end else begin
            sample_q <= keys;
            if (keys != sample_q) begin
                stable_cnt_q <= '0;
            end else if (stable_cnt_q != cnt_w'(debounce_cycles)) begin
                stable_cnt_q <= stable_cnt_q + 1'b1;
            end
            if (keys == sample_q && stable_cnt_q == cnt_w'(debounce_cycles - 1)) begin
                stable_q <= sample_q;
            end
        end
    end

    // Lowest pressed key wins
    always_comb begin
        note_enc = piano_cfg_pkg::note_rest;
        for (int i = nk - 1; i >= 0; i--) begin
            if (stable_q[i]) begin
                note_enc = nw'(i + 1);
            end
        end
    end

    // Press flag on rest to note or note to a different note
    always_ff @(posedge clock) begin
        if (rst) begin
            note_q  <= piano_cfg_pkg::note_rest;
            press_q <= 1'b0;
        end else begin
            note_q  <= note_enc;
            press_q <= (note_enc != piano_cfg_pkg::note_rest) && (note_enc != note_q);
        end
    end

    assign key_event = '{note: note_q, press: press_q};

    // Debounced keys cannot change on two edges in a row
    press_one_cycle: assert property (
        @(posedge clock) disable iff (rst)
        key_event.press |=> !key_event.press
    );

endmodule

// ==== song_memory.sv ====
/* Song memory and lesson registers behind a Wishbone classic slave
   Also gives the sequencer a registered read port into the song */
`timescale 1ns/1ps

module song_memory #(
    parameter int song_depth = 64
) (
    input  logic                                         clock,
    input  logic                                         rst,
    input  piano_types_pkg::wb_req_t                     wb_req,
    output piano_types_pkg::wb_rsp_t                     wb_rsp,
    input  logic [$clog2(song_depth)-1:0]                rd_addr,
    output piano_types_pkg::song_entry_t                 rd_entry,
    input  piano_types_pkg::lesson_status_t              status,
    output piano_types_pkg::lesson_cfg_t                 cfg
);

    localparam int aw  = $clog2(song_depth);
    localparam int dw  = piano_cfg_pkg::data_w;
    localparam int nw  = piano_cfg_pkg::note_w;
    localparam int lw  = piano_cfg_pkg::len_w;
    localparam int ow  = piano_cfg_pkg::oct_w;
    localparam int tw  = piano_cfg_pkg::timeout_w;

    logic [nw-1:0] ram [song_depth];

    logic          ack_q;
    logic [dw-1:0] rdata_q;
    logic [nw-1:0] rd_note_q;
    logic [lw-1:0] len_q;
    logic [ow-1:0] oct_q;
    logic [tw-1:0] tmo_q;
    logic          start_q;
    logic          req_ok;
    logic          wr_ok;
    logic          in_song;
    logic          is_ctrl;
    logic [dw-1:0] ctrl_word;

    // A new request is taken only when no acknowledge is pending
    assign req_ok  = wb_req.cyc && wb_req.stb && !ack_q;
    assign wr_ok   = req_ok && wb_req.we;
    assign in_song = wb_req.adr < song_depth;
    assign is_ctrl = wb_req.adr == piano_cfg_pkg::reg_ctrl_adr;

    always_comb begin
        ctrl_word = '0;
        ctrl_word[piano_cfg_pkg::ctrl_len_lsb +: lw] = len_q;
        ctrl_word[piano_cfg_pkg::ctrl_oct_lsb +: ow] = oct_q;
        ctrl_word[piano_cfg_pkg::ctrl_tmo_lsb +: tw] = tmo_q;
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req_ok;
        end
    end

    // Read data is captured with the acknowledge
    always_ff @(posedge clock) begin
        if (req_ok) begin
            if (in_song) begin
                rdata_q <= dw'(ram[wb_req.adr[aw-1:0]]);
            end else if (is_ctrl) begin
                rdata_q <= ctrl_word;
            end else if (wb_req.adr == piano_cfg_pkg::reg_status_adr) begin
                rdata_q <= dw'(status);
            end else begin
                rdata_q <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wr_ok && in_song) begin
            ram[wb_req.adr[aw-1:0]] <= wb_req.dat[nw-1:0];
        end
    end

    // Sequencer port, one cycle latency
    always_ff @(posedge clock) begin
        rd_note_q <= ram[rd_addr];
    end

    // Start bit is not stored, it only fires a pulse
    always_ff @(posedge clock) begin
        if (rst) begin
            len_q   <= '0;
            oct_q   <= '0;
            tmo_q   <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= wr_ok && is_ctrl && wb_req.dat[piano_cfg_pkg::ctrl_start_bit];
            if (wr_ok && is_ctrl) begin
                len_q <= wb_req.dat[piano_cfg_pkg::ctrl_len_lsb +: lw];
                oct_q <= wb_req.dat[piano_cfg_pkg::ctrl_oct_lsb +: ow];
                tmo_q <= wb_req.dat[piano_cfg_pkg::ctrl_tmo_lsb +: tw];
            end
        end
    end

    assign wb_rsp   = '{ack: ack_q, dat: rdata_q};
    assign rd_entry = '{note: rd_note_q};
    assign cfg      = '{length: len_q, octave: oct_q, timeout: tmo_q, start: start_q};

    // The master keeps cycle and strobe up until it sees acknowledge
    ack_during_request: assert property (
        @(posedge clock) disable iff (rst)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb
    );

endmodule

// ==== lesson_sequencer.sv ====
/* Lesson sequencer
   Steps through the song and judges each press or timeout as hit or miss */
`timescale 1ns/1ps

module lesson_sequencer #(
    parameter int song_depth = 64,
    parameter int count_w    = 8
) (
    input  logic                                 clock,
    input  logic                                 rst,
    input  piano_types_pkg::lesson_cfg_t         cfg,
    input  piano_types_pkg::key_event_t          key_event,
    output logic [$clog2(song_depth)-1:0]        rd_addr,
    input  piano_types_pkg::song_entry_t         rd_entry,
    output logic [piano_cfg_pkg::note_w-1:0]     expected_note,
    output piano_types_pkg::lesson_status_t      status
);

    localparam int aw = $clog2(song_depth);
    localparam int lw = piano_cfg_pkg::len_w;
    localparam int tw = piano_cfg_pkg::timeout_w;
    localparam int sw = piano_cfg_pkg::stat_cnt_w;

    logic               running_q;
    logic               done_q;
    logic               valid_q;
    logic [lw-1:0]      step_q;
    logic [lw-1:0]      len_q;
    logic [tw-1:0]      tmo_lim_q;
    logic [tw-1:0]      idle_q;
    logic [count_w-1:0] hits_q;
    logic [count_w-1:0] misses_q;
    logic [lw-1:0]      step_nxt;
    logic               timed_out;
    logic               judge;
    logic               hit;

    // A zero timeout turns the timeout off
    assign timed_out = (tmo_lim_q != '0) && (idle_q >= tmo_lim_q - 1'b1);

    // Nothing is judged while the entry for this step is still being read
    assign judge    = running_q && valid_q && (key_event.press || timed_out);
    assign hit      = key_event.press && (key_event.note == rd_entry.note);
    assign step_nxt = step_q + 1'b1;
    assign rd_addr  = step_q[aw-1:0];

    always_ff @(posedge clock) begin
        if (rst) begin
            running_q <= 1'b0;
            done_q    <= 1'b0;
            valid_q   <= 1'b0;
            step_q    <= '0;
            len_q     <= '0;
            tmo_lim_q <= '0;
            idle_q    <= '0;
            hits_q    <= '0;
            misses_q  <= '0;
        end else if (cfg.start) begin
            // Length and timeout are frozen for the whole lesson
            running_q <= cfg.length != '0;
            done_q    <= cfg.length == '0;
            valid_q   <= 1'b0;
            step_q    <= '0;
            len_q     <= cfg.length;
            tmo_lim_q <= cfg.timeout;
            idle_q    <= '0;
            hits_q    <= '0;
            misses_q  <= '0;
        end else if (running_q) begin
            valid_q <= 1'b1;
            idle_q  <= idle_q + 1'b1;
            if (judge) begin
                valid_q <= 1'b0;
                idle_q  <= '0;
                step_q  <= step_nxt;
                if (hit) begin
                    if (hits_q != '1) begin
                        hits_q <= hits_q + 1'b1;
                    end
                end else if (misses_q != '1) begin
                    misses_q <= misses_q + 1'b1;
                end
                if (step_nxt == len_q) begin
                    running_q <= 1'b0;
                    done_q    <= 1'b1;
                end
            end
        end
    end

    // Rest while the step's entry is not yet valid
    assign expected_note = (running_q && valid_q) ? rd_entry.note : piano_cfg_pkg::note_rest;

    assign status = '{
        running: running_q,
        done:    done_q,
        step:    step_q,
        hits:    sw'(hits_q),
        misses:  sw'(misses_q)
    };

    step_in_range: assert property (
        @(posedge clock) disable iff (rst)
        running_q |-> step_q < len_q
    );

endmodule

// ==== note_output.sv ====
/* Note output
   One-hot LED for the expected note and a square-wave tone for the held key */
`timescale 1ns/1ps

module note_output (
    input  logic                                 clock,
    input  logic                                 rst,
    input  logic [piano_cfg_pkg::note_w-1:0]     expected_note,
    input  piano_types_pkg::key_event_t          key_event,
    input  logic [piano_cfg_pkg::oct_w-1:0]      octave,
    output logic [piano_cfg_pkg::num_keys-1:0]   leds,
    output logic                                 tone
);

    localparam int nk = piano_cfg_pkg::num_keys;
    localparam int nw = piano_cfg_pkg::note_w;
    localparam int hw = piano_cfg_pkg::half_w;

    logic [nk-1:0] leds_q;
    logic [hw-1:0] half_len;
    logic [hw-1:0] phase_q;
    logic [nw-1:0] last_note_q;
    logic          tone_q;

    // Each octave up halves the period
    assign half_len = piano_cfg_pkg::note_half_period(key_event.note) >> octave;

    always_ff @(posedge clock) begin
        if (rst) begin
            leds_q <= '0;
        end else if (expected_note == piano_cfg_pkg::note_rest) begin
            leds_q <= '0;
        end else begin
            leds_q <= nk'(1) << (expected_note - 1'b1);
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            phase_q     <= '0;
            last_note_q <= piano_cfg_pkg::note_rest;
            tone_q      <= 1'b0;
        end else begin
            last_note_q <= key_event.note;
            // Silent at rest, and a new note starts from a fresh phase
            if (key_event.note == piano_cfg_pkg::note_rest || key_event.note != last_note_q) begin
                phase_q <= '0;
                tone_q  <= 1'b0;
            end else if (phase_q >= half_len - 1'b1) begin
                phase_q <= '0;
                tone_q  <= ~tone_q;
            end else begin
                phase_q <= phase_q + 1'b1;
            end
        end
    end

    assign leds = leds_q;
    assign tone = tone_q;

endmodule

// ==== piano_trainer_top.sv ====
/* Piano trainer top level
   Key scanner, song memory, lesson sequencer and note output */
`timescale 1ns/1ps

module piano_trainer_top #(
    parameter int song_depth      = 64,
    parameter int debounce_cycles = 8,
    parameter int count_w         = 8
) (
    input  logic                                clock,
    input  logic                                rst,
    input  logic [piano_cfg_pkg::num_keys-1:0]  keys,
    input  piano_types_pkg::wb_req_t            wb_req,
    output piano_types_pkg::wb_rsp_t            wb_rsp,
    output logic [piano_cfg_pkg::num_keys-1:0]  leds,
    output logic                                tone
);

    piano_types_pkg::key_event_t            key_event;
    piano_types_pkg::lesson_cfg_t           cfg;
    piano_types_pkg::lesson_status_t        status;
    piano_types_pkg::song_entry_t           rd_entry;
    logic [$clog2(song_depth)-1:0]          rd_addr;
    logic [piano_cfg_pkg::note_w-1:0]       expected_note;

    key_scanner #(.debounce_cycles(debounce_cycles)) key_scanner_i (
        .clock     (clock),
        .rst       (rst),
        .keys      (keys),
        .key_event (key_event)
    );

    song_memory #(.song_depth(song_depth)) song_memory_i (
        .clock    (clock),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .rd_addr  (rd_addr),
        .rd_entry (rd_entry),
        .status   (status),
        .cfg      (cfg)
    );

    lesson_sequencer #(.song_depth(song_depth), .count_w(count_w)) lesson_sequencer_i (
        .clock         (clock),
        .rst           (rst),
        .cfg           (cfg),
        .key_event     (key_event),
        .rd_addr       (rd_addr),
        .rd_entry      (rd_entry),
        .expected_note (expected_note),
        .status        (status)
    );

    // Octave comes straight from the control register
    note_output note_output_i (
        .clock         (clock),
        .rst           (rst),
        .expected_note (expected_note),
        .key_event     (key_event),
        .octave        (cfg.octave),
        .leds          (leds),
        .tone          (tone)
    );

endmodule

// ==== tb_piano_trainer.sv ====
/* Piano trainer testbench
   Random songs and presses checked against a reference model of the lesson */
`timescale 1ns/1ps

module tb_piano_trainer;

    localparam int depth = 16;

    logic                                clock;
    logic                                rst;
    logic [piano_cfg_pkg::num_keys-1:0]  keys;
    piano_types_pkg::wb_req_t            wb_req;
    piano_types_pkg::wb_rsp_t            wb_rsp;
    logic [piano_cfg_pkg::num_keys-1:0]  leds;
    logic                                tone;

    logic [31:0] rand_state;
    int          mismatches;
    int          failures;
    int          song_model [depth];
    int          model_hits;
    int          model_misses;

    piano_trainer_top #(.song_depth(depth), .debounce_cycles(8)) dut_i (
        .clock  (clock),
        .rst    (rst),
        .keys   (keys),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .leds   (leds),
        .tone   (tone)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic logic [31:0] lcg_next();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    // Equal temperament from C4, half period in cycles of a 1 MHz clock
    function automatic int half_period_ref(input int note);
        real freq;
        freq = 261.6256 * (2.0 ** ((note - 1) / 12.0));
        return $rtoi(1.0e6 / (2.0 * freq) + 0.5);
    endfunction

    function automatic logic [31:0] ctrl_word(input int len, input int oct, input int tmo,
                                              input logic start);
        logic [31:0] w;
        w = '0;
        w[piano_cfg_pkg::ctrl_len_lsb +: 8]   = 8'(len);
        w[piano_cfg_pkg::ctrl_oct_lsb +: 2]   = 2'(oct);
        w[piano_cfg_pkg::ctrl_tmo_lsb +: 16]  = 16'(tmo);
        w[piano_cfg_pkg::ctrl_start_bit]      = start;
        return w;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatches++;
        $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
    endtask

    // One Wishbone classic cycle, held until acknowledge
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        int waited;
        waited = 0;
        rdat = '0;
        @(posedge clock);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        @(negedge clock);
        while (!wb_rsp.ack && waited < 16) begin
            @(negedge clock);
            waited++;
        end
        if (wb_rsp.ack) begin
            rdat = wb_rsp.dat;
        end else begin
            failures++;
            $display("No acknowledge for Wishbone access to address %0h", adr);
        end
        @(posedge clock);
        wb_req <= '0;
    endtask

    task automatic read_status(output piano_types_pkg::lesson_status_t st);
        logic [31:0] rd;
        wb_access(1'b0, piano_cfg_pkg::reg_status_adr, '0, rd);
        st = rd[$bits(piano_types_pkg::lesson_status_t)-1:0];
    endtask

    // Press one key, hold it, then let the release settle
    task automatic play_note(input int note, input int hold);
        @(posedge clock);
        keys <= 13'(1) << (note - 1);
        repeat (hold) @(posedge clock);
        keys <= '0;
        repeat (16) @(posedge clock);
    endtask

    initial begin
        logic [31:0]                      rd;
        piano_types_pkg::lesson_status_t  st;
        int                               note;
        int                               oct;
        int                               exp_half;
        int                               toggles;
        int                               cyc;
        int                               stamp [3];
        logic                             prev;

        rst        = 1'b1;
        keys       = '0;
        wb_req     = '0;
        rand_state = 32'haed1dca9;
        mismatches = 0;
        failures   = 0;
        repeat (4) @(posedge clock);
        rst <= 1'b0;

        // Song memory read-back
        for (int i = 0; i < depth; i++) begin
            song_model[i] = 1 + int'(lcg_next() % 32'd13);
            wb_access(1'b1, 8'(i), 32'(song_model[i]), rd);
        end
        for (int i = 0; i < depth; i++) begin
            wb_access(1'b0, 8'(i), '0, rd);
            if (rd != 32'(song_model[i])) begin
                report_mismatch($sformatf("song[%0d]", i), rd, 32'(song_model[i]));
            end
        end

        // Judging presses, with the LED checked before each step
        model_hits   = 0;
        model_misses = 0;
        wb_access(1'b1, piano_cfg_pkg::reg_ctrl_adr, ctrl_word(10, 0, 2000, 1'b1), rd);
        repeat (4) @(negedge clock);
        for (int s = 0; s < 10; s++) begin
            @(negedge clock);
            if (leds != 13'(1) << (song_model[s] - 1)) begin
                report_mismatch("leds", 32'(leds), 32'(13'(1) << (song_model[s] - 1)));
            end
            if (lcg_next() % 32'd2 == 0) begin
                note = song_model[s];
                model_hits++;
            end else begin
                note = (song_model[s] + int'(lcg_next() % 32'd12)) % 13 + 1;
                model_misses++;
            end
            play_note(note, 12 + int'(lcg_next() % 32'd8));
        end
        read_status(st);
        if (st.hits != 10'(model_hits)) begin
            report_mismatch("status.hits", 32'(st.hits), 32'(model_hits));
        end
        if (st.misses != 10'(model_misses)) begin
            report_mismatch("status.misses", 32'(st.misses), 32'(model_misses));
        end
        if (st.done != 1'b1) begin
            report_mismatch("status.done", 32'(st.done), 32'd1);
        end
        @(negedge clock);
        if (leds != '0) begin
            report_mismatch("leds", 32'(leds), 32'd0);
        end

        // Timeouts with no key pressed
        wb_access(1'b1, piano_cfg_pkg::reg_ctrl_adr, ctrl_word(5, 0, 24, 1'b1), rd);
        cyc = 0;
        read_status(st);
        while (!st.done && cyc < 200) begin
            read_status(st);
            cyc++;
        end
        if (!st.done) begin
            failures++;
            $display("Lesson with timeouts never reached done");
        end
        if (st.misses != 10'd5) begin
            report_mismatch("status.misses", 32'(st.misses), 32'd5);
        end
        if (st.hits != 10'd0) begin
            report_mismatch("status.hits", 32'(st.hits), 32'd0);
        end

        // A short glitch must not be judged
        wb_access(1'b1, piano_cfg_pkg::reg_ctrl_adr, ctrl_word(3, 0, 0, 1'b1), rd);
        repeat (4) @(posedge clock);
        keys <= 13'(1) << (song_model[0] - 1);
        repeat (1 + int'(lcg_next() % 32'd7)) @(posedge clock);
        keys <= '0;
        repeat (20) @(posedge clock);
        read_status(st);
        if (st.step != 8'd0) begin
            report_mismatch("status.step", 32'(st.step), 32'd0);
        end
        play_note(song_model[0], 12);
        read_status(st);
        if (st.step != 8'd1) begin
            report_mismatch("status.step", 32'(st.step), 32'd1);
        end
        if (st.hits != 10'd1) begin
            report_mismatch("status.hits", 32'(st.hits), 32'd1);
        end
        if (st.misses != 10'd0) begin
            report_mismatch("status.misses", 32'(st.misses), 32'd0);
        end

        // Tone period at a random key and octave, with the lesson stopped
        for (int t = 0; t < 2; t++) begin
            note = 1 + int'(lcg_next() % 32'd13);
            oct  = int'(lcg_next() % 32'd4);
            exp_half = half_period_ref(note) >> oct;
            wb_access(1'b1, piano_cfg_pkg::reg_ctrl_adr, ctrl_word(0, oct, 0, 1'b1), rd);
            @(posedge clock);
            keys <= 13'(1) << (note - 1);
            toggles = 0;
            cyc = 0;
            prev = tone;
            while (toggles < 3 && cyc < 8000) begin
                @(negedge clock);
                cyc++;
                if (tone != prev) begin
                    stamp[toggles] = cyc;
                    toggles++;
                    prev = tone;
                end
            end
            if (toggles < 3) begin
                failures++;
                $display("Tone did not toggle for note %0d at octave %0d", note, oct);
            end else if (stamp[2] - stamp[1] != exp_half) begin
                report_mismatch("tone half period", 32'(stamp[2] - stamp[1]), 32'(exp_half));
            end
            @(posedge clock);
            keys <= '0;
            repeat (20) @(negedge clock);
            if (tone != 1'b0) begin
                report_mismatch("tone", 32'(tone), 32'd0);
            end
        end

        $display("Run finished with %0d mismatches and %0d other failures",
                 mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== all.f ====
piano_cfg_pkg.sv
piano_types_pkg.sv
key_scanner.sv
song_memory.sv
lesson_sequencer.sv
note_output.sv
piano_trainer_top.sv
tb_piano_trainer.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the piano trainer simulation with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_piano_trainer -f all.f -o sim_piano_trainer
./obj_dir/sim_piano_trainer > sim.log 2>&1 || true
cat sim.log

# The log decides pass or fail
grep -q "=== PASS ===" sim.log
